// ==== common/rv_decode_pkg.sv ====
package rv_decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_ARI_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_ARI_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_CSR       = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_copy_b = 4'd10   // lui passes the immediate through
    } alu_op_e;

    // raw instruction fields plus the format-selected immediate
    typedef struct packed {
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;
    } dec_fields_t;

    // registered output of the decode stage
    typedef struct packed {
        alu_op_e               alu_op;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic                  is_jump;
        logic                  is_branch;
        logic                  a_sel;      // 1 selects rs1 data
        logic                  b_sel;      // 1 selects the immediate
        logic                  reg_we;
        logic                  mem_we;     // stores
        logic                  mem_rr;     // loads
        logic                  csr_write;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
    } dec_ctrl_t;

    // write-back request into the register file
    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } wb_req_t;

endpackage

// ==== hdl/instr_fields.sv ====
`timescale 1ns/1ps

module instr_fields import rv_decode_pkg::*; (
    input  logic [xlen-1:0] instr,
    output dec_fields_t     fields
);

    logic [6:0]      opcode;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign opcode = instr[6:0];

    // immediates for every format, picked below by opcode
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        fields.opcode = opcode;
        fields.funct3 = instr[14:12];
        fields.funct7 = instr[31:25];
        fields.rd     = instr[11:7];
        fields.rs1    = instr[19:15];
        fields.rs2    = instr[24:20];   // also the shift amount for shift immediates

        case (opcode)
            OPC_LOAD,
            OPC_JALR,
            OPC_ARI_ITYPE,
            OPC_CSR: begin
                fields.imm = imm_i;
            end
            OPC_STORE: begin
                fields.imm = imm_s;
            end
            OPC_BRANCH: begin
                fields.imm = imm_b;
            end
            OPC_LUI,
            OPC_AUIPC: begin
                fields.imm = imm_u;
            end
            OPC_JAL: begin
                fields.imm = imm_j;
            end
            default: begin
                fields.imm = '0;   // r-type and unknown words
            end
        endcase
    end

endmodule

// ==== hdl/alu_ctrl_dec.sv ====
`timescale 1ns/1ps

module alu_ctrl_dec import rv_decode_pkg::*; (
    input  dec_fields_t fields,
    output alu_op_e     alu_op
);

    logic    alt;          // funct7 bit 5, sub / sra select
    alu_op_e arith_op;

    assign alt = fields.funct7[5];

    // shared funct3 map for r-type and i-type arithmetic
    always_comb begin
        case (fields.funct3)
            3'b000:  arith_op = (alt && fields.opcode == OPC_ARI_RTYPE) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        case (fields.opcode)
            OPC_ARI_RTYPE,
            OPC_ARI_ITYPE: begin
                alu_op = arith_op;
            end
            OPC_LUI: begin
                alu_op = alu_copy_b;
            end
            default: begin
                alu_op = alu_add;   // address and pc arithmetic
            end
        endcase
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  wb_req_t               wb,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    logic [xlen-1:0] regs [1:num_regs-1];   // x0 has no storage
    logic            wr_en;

    assign wr_en = wb.en && (wb.addr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // read with same-cycle write forwarding
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wb.addr == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
    end

    always_comb begin
        rs2_data = read_port(rs2);
    end

endmodule

// ==== decode/decode_read.sv ====
`timescale 1ns/1ps

module decode_read import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            bubble,
    input  dec_fields_t     fields,
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output dec_ctrl_t       ctrl
);

    dec_ctrl_t nxt;
    logic      is_store;

    assign is_store = fields.opcode == OPC_STORE;

    always_comb begin
        nxt          = '0;
        nxt.alu_op   = alu_op;
        nxt.funct3   = fields.funct3;
        nxt.rd       = fields.rd;
        nxt.imm      = fields.imm;
        nxt.rs1_data = rs1_data;
        nxt.rs2_data = rs2_data;

        nxt.is_jump   = fields.opcode inside {OPC_JAL, OPC_JALR, OPC_BRANCH};
        nxt.is_branch = fields.opcode == OPC_BRANCH;
        nxt.a_sel     = fields.opcode inside {OPC_LOAD, OPC_STORE, OPC_ARI_RTYPE,
                                              OPC_ARI_ITYPE, OPC_CSR};
        nxt.reg_we    = fields.opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                              OPC_LOAD, OPC_ARI_ITYPE, OPC_ARI_RTYPE};
        nxt.mem_we    = is_store;
        nxt.mem_rr    = fields.opcode == OPC_LOAD;
        nxt.csr_write = fields.opcode == OPC_CSR;

        // store and r-type take rs2
        nxt.b_sel     = fields.opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                              OPC_BRANCH, OPC_LOAD, OPC_CSR, OPC_ARI_ITYPE};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl.is_jump   <= 1'b0;
            ctrl.is_branch <= 1'b0;
            ctrl.a_sel     <= 1'b0;
            ctrl.b_sel     <= 1'b0;
            ctrl.reg_we    <= 1'b0;
            ctrl.mem_we    <= 1'b0;
            ctrl.mem_rr    <= 1'b0;
            ctrl.csr_write <= 1'b0;
        end else if (bubble) begin   // squash side effects and keep the rest
            ctrl.is_jump   <= 1'b0;
            ctrl.is_branch <= 1'b0;
            ctrl.reg_we    <= 1'b0;
            ctrl.mem_we    <= 1'b0;
            ctrl.mem_rr    <= 1'b0;
            ctrl.csr_write <= 1'b0;
        end else if (!stall) begin
            ctrl <= nxt;
        end
    end

endmodule

// ==== hdl/decode_top.sv ====
`timescale 1ns/1ps

module decode_top import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            bubble,
    input  logic [xlen-1:0] instr,
    input  wb_req_t         wb,
    output dec_ctrl_t       ctrl
);

    dec_fields_t     fields;
    alu_op_e         alu_op;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    instr_fields u_fields (
        .instr  (instr),
        .fields (fields)
    );

    alu_ctrl_dec u_alu_dec (
        .fields (fields),
        .alu_op (alu_op)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb),
        .rs1      (fields.rs1),
        .rs2      (fields.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode_read u_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .bubble   (bubble),
        .fields   (fields),
        .alu_op   (alu_op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ctrl     (ctrl)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 10;
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;   // released with the other inputs
    end

endmodule

// ==== dv/decode_checker.sv ====
`timescale 1ns/1ps

module decode_checker import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            bubble,
    input  logic [xlen-1:0] instr,
    input  wb_req_t         wb,
    input  dec_ctrl_t       ctrl,
    output int              cycles_checked,
    output int              error_count,
    output int              check_count
);

    logic [xlen-1:0] mirror [0:num_regs-1];
    dec_ctrl_t       exp_ctrl;
    logic            flags_known = 1'b0;
    logic            data_known  = 1'b0;
    string           ctx         = "idle";
    int              cycles      = 0;
    int              errors      = 0;
    int              checks      = 0;

    assign cycles_checked = cycles;
    assign error_count    = errors;
    assign check_count    = checks;

    // sign-extended immediate by instruction format
    function automatic logic [xlen-1:0] format_imm(input logic [xlen-1:0] w);
        case (w[6:0])
            OPC_LOAD, OPC_JALR, OPC_ARI_ITYPE, OPC_CSR: return {{20{w[31]}}, w[31:20]};
            OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: return {w[31:12], 12'h000};
            OPC_JAL:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:    return '0;
        endcase
    endfunction

    function automatic alu_op_e alu_op_of(input logic [xlen-1:0] w);
        logic [6:0] opc;
        logic       alt;
        alu_op_e    op;
        opc = w[6:0];
        alt = w[30];   // funct7 bit 5
        op  = alu_add;
        if (opc == OPC_LUI) begin
            op = alu_copy_b;
        end else if (opc == OPC_ARI_RTYPE || opc == OPC_ARI_ITYPE) begin
            case (w[14:12])
                3'd0:    op = (alt && opc == OPC_ARI_RTYPE) ? alu_sub : alu_add;
                3'd1:    op = alu_sll;
                3'd2:    op = alu_slt;
                3'd3:    op = alu_sltu;
                3'd4:    op = alu_xor;
                3'd5:    op = alt ? alu_sra : alu_srl;
                3'd6:    op = alu_or;
                default: op = alu_and;
            endcase
        end
        return op;
    endfunction

    // {is_jump, is_branch, a_sel, b_sel, reg_we, mem_we, mem_rr, csr_write}
    function automatic logic [7:0] class_flags(input logic [6:0] opc);
        case (opc)
            OPC_LUI:       return 8'b0001_1000;
            OPC_AUIPC:     return 8'b0001_1000;
            OPC_JAL:       return 8'b1001_1000;
            OPC_JALR:      return 8'b1001_1000;
            OPC_BRANCH:    return 8'b1101_0000;
            OPC_LOAD:      return 8'b0011_1010;
            OPC_STORE:     return 8'b0010_0100;
            OPC_ARI_ITYPE: return 8'b0011_1000;
            OPC_ARI_RTYPE: return 8'b0010_1000;
            OPC_CSR:       return 8'b0011_0001;
            default:       return 8'b0000_0000;
        endcase
    endfunction

    function automatic string opcode_name(input logic [6:0] opc);
        case (opc)
            OPC_LUI:       return "lui";
            OPC_AUIPC:     return "auipc";
            OPC_JAL:       return "jal";
            OPC_JALR:      return "jalr";
            OPC_BRANCH:    return "branch";
            OPC_LOAD:      return "load";
            OPC_STORE:     return "store";
            OPC_ARI_ITYPE: return "ari_itype";
            OPC_ARI_RTYPE: return "ari_rtype";
            OPC_CSR:       return "csr";
            default:       return "unknown";
        endcase
    endfunction

    function automatic logic [7:0] flags_of(input dec_ctrl_t c);
        return {c.is_jump, c.is_branch, c.a_sel, c.b_sel, c.reg_we, c.mem_we, c.mem_rr,
                c.csr_write};
    endfunction

    function automatic dec_ctrl_t with_flags(input dec_ctrl_t c, input logic [7:0] f);
        dec_ctrl_t r;
        r = c;
        {r.is_jump, r.is_branch, r.a_sel, r.b_sel, r.reg_we, r.mem_we, r.mem_rr,
         r.csr_write} = f;
        return r;
    endfunction

    // register read before the edge with the new data winning on a same-cycle write
    function automatic logic [xlen-1:0] mirror_read(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) return '0;
        if (wb.en && wb.addr == addr) return wb.data;
        return mirror[addr];
    endfunction

    function automatic dec_ctrl_t predict(input logic [xlen-1:0] w);
        dec_ctrl_t c;
        c          = '0;
        c.alu_op   = alu_op_of(w);
        c.funct3   = w[14:12];
        c.rd       = w[11:7];
        c.imm      = format_imm(w);
        c.rs1_data = mirror_read(w[19:15]);
        c.rs2_data = mirror_read(w[24:20]);
        return with_flags(c, class_flags(w[6:0]));
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_ctrl    = with_flags(exp_ctrl, 8'h00);
            flags_known = 1'b1;
            ctx         = "reset";
            for (int i = 0; i < num_regs; i++) begin
                mirror[i] = '0;
            end
        end else begin
            if (bubble) begin
                exp_ctrl = with_flags(exp_ctrl, flags_of(exp_ctrl) & 8'b0011_0000);
                ctx      = stall ? "bubble_over_stall" : "bubble";
            end else if (stall) begin
                ctx = "stall";   // everything held
            end else begin
                exp_ctrl   = predict(instr);
                data_known = 1'b1;
                ctx        = opcode_name(instr[6:0]);
            end
            if (wb.en && wb.addr != '0) begin
                mirror[wb.addr] = wb.data;
            end
        end
    end

    always @(negedge clk) begin
        if (flags_known) begin
            compare({ctx, ".flags"}, 32'(flags_of(exp_ctrl)), 32'(flags_of(ctrl)));
            if (data_known) begin
                compare({ctx, ".alu_op"}, 32'(exp_ctrl.alu_op), 32'(ctrl.alu_op));
                compare({ctx, ".funct3"}, 32'(exp_ctrl.funct3), 32'(ctrl.funct3));
                compare({ctx, ".rd"}, 32'(exp_ctrl.rd), 32'(ctrl.rd));
                compare({ctx, ".imm"}, exp_ctrl.imm, ctrl.imm);
                compare({ctx, ".rs1_data"}, exp_ctrl.rs1_data, ctrl.rs1_data);
                compare({ctx, ".rs2_data"}, exp_ctrl.rs2_data, ctrl.rs2_data);
            end
            cycles++;
        end
    end

endmodule

// ==== dv/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb import rv_decode_pkg::*; ();

    localparam int num_instr     = 2000;
    localparam int drive_delay   = 2;
    localparam int reset_timeout = 10;
    localparam int drain_timeout = 10;

    logic            clk;
    logic            rst_n;
    logic            stall;
    logic            bubble;
    logic [xlen-1:0] instr;
    wb_req_t         wb;
    dec_ctrl_t       ctrl;
    int              cycles_checked;
    int              error_count;
    int              check_count;
    logic [31:0]     lcg_state;

    tb_clk_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .bubble (bubble),
        .instr  (instr),
        .wb     (wb),
        .ctrl   (ctrl)
    );

    decode_checker chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .bubble         (bubble),
        .instr          (instr),
        .wb             (wb),
        .ctrl           (ctrl),
        .cycles_checked (cycles_checked),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [6:0] pick_opcode(input int idx);
        case (idx)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_ARI_ITYPE;
            8:       return OPC_ARI_RTYPE;
            default: return OPC_CSR;
        endcase
    endfunction

    task automatic drive_cycle();
        logic [31:0] r_sel;
        logic [31:0] r_bits;
        logic [31:0] r_ctl;
        logic [31:0] word;
        r_sel  = next_rand();
        r_bits = next_rand();
        r_ctl  = next_rand();
        if (r_sel[27:24] == 4'd0) begin
            word = r_bits;   // raw word, mostly an unknown opcode
        end else begin
            word = {r_bits[31:7], pick_opcode(int'(r_sel[31:16]) % 10)};
        end
        instr   = word;
        wb.en   = r_ctl[31];
        wb.data = next_rand();
        case (r_ctl[20:19])
            2'd0:    wb.addr = word[19:15];   // hits the rs1 bypass
            2'd1:    wb.addr = word[24:20];
            default: wb.addr = r_ctl[26:22];
        endcase
        stall  = (r_ctl[30:28] == 3'd0);
        bubble = (int'(r_ctl[17:2]) % 10 == 0);
    endtask

    initial begin
        int waited;
        int target;
        bit run_ok;
        lcg_state = 32'he8ca;
        stall     = 1'b0;
        bubble    = 1'b0;
        instr     = '0;
        wb        = '0;
        run_ok    = 1'b1;
        waited    = 0;

        while (rst_n !== 1'b1 && waited < reset_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", reset_timeout);
            run_ok = 1'b0;
        end

        if (run_ok) begin
            for (int n = 0; n < num_instr; n++) begin
                #(drive_delay);
                drive_cycle();
                @(posedge clk);
            end
            target = cycles_checked + 1;   // edge that captured the last word
            waited = 0;
            while (cycles_checked < target && waited < drain_timeout) begin
                @(negedge clk);
                #1;
                waited++;
            end
            if (cycles_checked < target) begin
                $display("checker did not finish the last comparison within %0d cycles",
                         drain_timeout);
                run_ok = 1'b0;
            end
        end

        $display("cycles checked: %0d, checks: %0d, errors: %0d",
                 cycles_checked, check_count, error_count);
        if (run_ok && error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/rv_decode_pkg.sv
hdl/instr_fields.sv
hdl/alu_ctrl_dec.sv
hdl/reg_file.sv
decode/decode_read.sv
hdl/decode_top.sv
dv/tb_clk_gen.sv
dv/decode_checker.sv
dv/decode_tb.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing -j 0
TOP   := decode_tb
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log
PASS  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run the simulation and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
